//--- rv_core.f
+incdir+design
design/core_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/rv_core.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

//--- test/tb_top.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_top;

  localparam int               NUM_INSTR = 2000;
  // About 2860 cycles at 70% density plus reset and drain margin
  localparam int               MAX_CYCLES = NUM_INSTR * 3;
  localparam int               SEED = 69;
  localparam logic [`XLEN-1:0] BOOT_ADDR = 32'h0000_1000;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  logic                     clk;
  logic                     rst_n;
  logic [`XLEN-1:0]         boot_addr;
  logic                     instr_valid;
  logic [`XLEN-1:0]         instr_word;
  logic                     wb_valid;
  logic [`REG_ADDR_W-1:0]   wb_rd;
  logic [`XLEN-1:0]         wb_data;
  logic [`XLEN-1:0]         wb_pc;
  logic                     illegal;
  logic [`RETIRE_CNT_W-1:0] retire_count;
  int                       value_errors;
  int                       protocol_errors;
  int                       checked;
  int                       cycle_cnt = 0;

  tb_clock clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  rv_core dut0
  (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .boot_addr_i    ( boot_addr    ),
    .instr_valid_i  ( instr_valid  ),
    .instr_i        ( instr_word   ),
    .wb_valid_o     ( wb_valid     ),
    .wb_rd_o        ( wb_rd        ),
    .wb_data_o      ( wb_data      ),
    .wb_pc_o        ( wb_pc        ),
    .illegal_o      ( illegal      ),
    .retire_count_o ( retire_count )
  );

  tb_checker checker0
  (
    .clk_i             ( clk             ),
    .rst_n_i           ( rst_n           ),
    .boot_addr_i       ( boot_addr       ),
    .instr_valid_i     ( instr_valid     ),
    .instr_i           ( instr_word      ),
    .wb_valid_i        ( wb_valid        ),
    .wb_rd_i           ( wb_rd           ),
    .wb_data_i         ( wb_data         ),
    .wb_pc_i           ( wb_pc           ),
    .illegal_i         ( illegal         ),
    .retire_count_i    ( retire_count    ),
    .value_errors_o    ( value_errors    ),
    .protocol_errors_o ( protocol_errors ),
    .checked_o         ( checked         )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Instruction mix
  ////////////////////////////////////////////////////////////////////////////

  // Mostly x0 to x7 so that close dependences are frequent
  function automatic logic [4:0] pick_reg();
    int unsigned r;
    r = ($urandom_range(99) < 85) ? $urandom_range(7) : $urandom_range(31);
    return r[4:0];
  endfunction

  function automatic logic [`XLEN-1:0] make_instr();
    int unsigned      kind;
    logic [31:0]      rnd;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] w;
    kind = $urandom_range(99);
    rnd  = $urandom();
    f3   = rnd[2:0];
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f7   = ((f3 == 3'd0 || f3 == 3'd5) && rnd[8]) ? 7'h20 : 7'h00;
    if (kind < 5) begin
      // Load, branch, M extension, SLLI with a bad funct7
      case (rnd[10:9])
        2'd0:    w = {rnd[31:20], rs1, f3, rd, 7'b0000011};
        2'd1:    w = {rnd[31:7], 7'b1100011};
        2'd2:    w = {7'h01, rs2, rs1, f3, rd, OPC_OP};
        default: w = {7'h20, rnd[24:20], rs1, 3'b001, rd, OPC_OP_IMM};
      endcase
    end else if (kind < 45) begin
      w = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 85) begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        w = {f7, rnd[24:20], rs1, f3, rd, OPC_OP_IMM};
      end else begin
        w = {rnd[31:20], rs1, f3, rd, OPC_OP_IMM};
      end
    end else if (kind < 93) begin
      w = {rnd[31:12], rd, OPC_LUI};
    end else begin
      w = {rnd[31:12], rd, OPC_AUIPC};
    end
    return w;
  endfunction

  task automatic print_summary();
    $display("Summary: %0d of %0d checked, %0d value errors, %0d protocol errors",
             checked, NUM_INSTR, value_errors, protocol_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and end of run
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          sent;
    int unsigned seed_val;
    sent        = 0;
    boot_addr   = BOOT_ADDR;
    instr_valid = 1'b0;
    instr_word  = '0;
    seed_val    = $urandom(SEED);
    while (rst_n !== 1'b1) begin
      @(posedge clk);
    end
    // Strobe high about 70% of cycles with a garbage word otherwise
    while (sent < NUM_INSTR) begin
      @(posedge clk);
      if ($urandom_range(99) < 70) begin
        instr_valid <= 1'b1;
        instr_word  <= make_instr();
        sent++;
      end else begin
        instr_valid <= 1'b0;
        instr_word  <= $urandom();
      end
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    // Drain by reading between edges
    while (checked < NUM_INSTR) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    print_summary();
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles before all outputs arrived", MAX_CYCLES);
      print_summary();
      $display("Verification failed");
      $finish;
    end
  end

endmodule

//--- test/tb_checker.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_checker
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`XLEN-1:0]         boot_addr_i,

  // Stimulus as the DUT sees it
  input  logic                     instr_valid_i,
  input  logic [`XLEN-1:0]         instr_i,

  // DUT writeback view
  input  logic                     wb_valid_i,
  input  logic [`REG_ADDR_W-1:0]   wb_rd_i,
  input  logic [`XLEN-1:0]         wb_data_i,
  input  logic [`XLEN-1:0]         wb_pc_i,
  input  logic                     illegal_i,
  input  logic [`RETIRE_CNT_W-1:0] retire_count_i,

  output int                       value_errors_o,
  output int                       protocol_errors_o,
  output int                       checked_o
);

  // Accept edge to the sampling edge of the output
  localparam int LATENCY = 3;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // One expected retirement
  typedef struct packed {
    logic                     illegal;
    logic [`REG_ADDR_W-1:0]   rd;
    logic [`XLEN-1:0]         data;
    logic [`XLEN-1:0]         pc;
    logic [`RETIRE_CNT_W-1:0] count;
    logic [31:0]              cycle;
  } expect_t;

  // Architectural model
  logic [`XLEN-1:0]         model_regs [`NUM_REGS];
  logic [`XLEN-1:0]         model_pc;
  logic [`RETIRE_CNT_W-1:0] model_count;
  logic [`RETIRE_CNT_W-1:0] last_count;
  expect_t                  exp_q [$];
  int                       cycle;

  initial begin
    value_errors_o    = 0;
    protocol_errors_o = 0;
    checked_o         = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // ISA model
  ////////////////////////////////////////////////////////////////////////////

  // Alternate funct7 only on SUB, SRA, SRAI
  function automatic logic is_legal(input logic [`XLEN-1:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
      OPC_OP:     ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          ok = (f7 == 7'h00);
        end else if (f3 == 3'd5) begin
          ok = (f7 == 7'h00) || (f7 == 7'h20);
        end else begin
          ok = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: ok = 1'b1;
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  // Integer ops by funct3
  function automatic logic [`XLEN-1:0] int_op(input logic [2:0] f3, input logic alt,
                                              input logic [`XLEN-1:0] a,
                                              input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5:    r = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Executes in program order, so any dependence distance is covered
  task automatic accept_instr(input logic [`XLEN-1:0] w);
    expect_t          e;
    logic [`XLEN-1:0] rs1_v;
    logic [`XLEN-1:0] rs2_v;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    rs1_v   = model_regs[w[19:15]];
    rs2_v   = model_regs[w[24:20]];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_u   = {w[31:12], 12'b0};
    e.illegal = !is_legal(w);
    e.rd      = w[11:7];
    e.pc      = model_pc;
    e.cycle   = cycle;
    e.data    = '0;
    if (!e.illegal) begin
      case (w[6:0])
        OPC_OP:     e.data = int_op(w[14:12], w[30], rs1_v, rs2_v);
        OPC_OP_IMM: e.data = int_op(w[14:12], w[30] && (w[14:12] == 3'd5), rs1_v, imm_i);
        OPC_LUI:    e.data = imm_u;
        default:    e.data = model_pc + imm_u;
      endcase
      // x0 keeps zero, the result is still reported
      if (e.rd != '0) begin
        model_regs[e.rd] = e.data;
      end
      model_count = model_count + 1'b1;
    end
    e.count = model_count;
    exp_q.push_back(e);
    model_pc = model_pc + 32'd4;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      value_errors_o++;
      $display("ERROR %s at cycle %0d: expected %h, actual %h", name, cycle, exp_v, act_v);
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    logic    due;
    due = (exp_q.size() > 0) && (exp_q[0].cycle + LATENCY <= cycle);
    if (wb_valid_i && illegal_i) begin
      protocol_errors_o++;
      $display("Cycle %0d: wb_valid_o and illegal_o are high together", cycle);
    end
    if (wb_valid_i || illegal_i) begin
      if (exp_q.size() == 0) begin
        protocol_errors_o++;
        $display("Cycle %0d: output seen with no instruction outstanding", cycle);
      end else begin
        e = exp_q.pop_front();
        checked_o++;
        compare_value("latency", e.cycle + LATENCY, cycle);
        compare_value("illegal_flag", {31'b0, e.illegal}, {31'b0, illegal_i});
        compare_value("pc_sequence", e.pc, wb_pc_i);
        if (!e.illegal) begin
          compare_value("dest_reg", {27'b0, e.rd}, {27'b0, wb_rd_i});
          compare_value("alu_result", e.data, wb_data_i);
        end
        compare_value("retire_count", {16'b0, e.count}, {16'b0, retire_count_i});
        last_count = e.count;
      end
    end else begin
      if (due) begin
        e = exp_q.pop_front();
        checked_o++;
        protocol_errors_o++;
        last_count = e.count;
        $display("Cycle %0d: no output for the instruction at pc %h", cycle, e.pc);
      end
      // Counter holds between retirements, zero before the first
      compare_value("retire_count_idle", {16'b0, last_count}, {16'b0, retire_count_i});
    end
  endtask

  // Outputs are read before this edge updates them
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
      model_pc    = boot_addr_i;
      model_count = '0;
      last_count  = '0;
      cycle       = 0;
      exp_q.delete();
    end else begin
      cycle++;
      check_outputs();
      if (instr_valid_i) begin
        accept_instr(instr_i);
      end
    end
  end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
  output logic clk_o,
  output logic rst_n_o
);

  localparam int PERIOD_NS    = 100;
  localparam int RESET_CYCLES = 4;

  // Free running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Synchronous reset held low over the first rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module rv_core import core_pkg::*;
(
  // Clock and reset
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Static start address
  input  logic [`XLEN-1:0]         boot_addr_i,

  // Instruction strobe
  input  logic                     instr_valid_i,
  input  logic [`XLEN-1:0]         instr_i,

  // Writeback observation
  output logic                     wb_valid_o,
  output logic [`REG_ADDR_W-1:0]   wb_rd_o,
  output logic [`XLEN-1:0]         wb_data_o,
  output logic [`XLEN-1:0]         wb_pc_o,
  output logic                     illegal_o,
  output logic [`RETIRE_CNT_W-1:0] retire_count_o
);

  // Pipeline payloads
  if_id_pipe_t            if_id_pipe;
  id_ex_pipe_t            id_ex_pipe;
  ex_wb_pipe_t            ex_wb_pipe;

  // EX result forward into decode
  logic                   ex_fwd_we;
  logic [`REG_ADDR_W-1:0] ex_fwd_rd;
  logic [`XLEN-1:0]       ex_fwd_data;

  // Register file write from WB, also forwarded
  logic                   rf_we_wb;
  logic [`REG_ADDR_W-1:0] rf_waddr_wb;
  logic [`XLEN-1:0]       rf_wdata_wb;

  // Register file read ports
  logic [`REG_ADDR_W-1:0] rf_raddr_a;
  logic [`REG_ADDR_W-1:0] rf_raddr_b;
  logic [`XLEN-1:0]       rf_rdata_a;
  logic [`XLEN-1:0]       rf_rdata_b;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////////////////////////////

  fetch_stage fetch_stage_i
  (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .boot_addr_i    ( boot_addr_i   ),
    .instr_valid_i  ( instr_valid_i ),
    .instr_i        ( instr_i       ),
    .if_id_o        ( if_id_pipe    )
  );

  decode_stage decode_stage_i
  (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .if_id_i        ( if_id_pipe    ),
    .ex_fwd_we_i    ( ex_fwd_we     ),
    .ex_fwd_rd_i    ( ex_fwd_rd     ),
    .ex_fwd_data_i  ( ex_fwd_data   ),
    .wb_we_i        ( rf_we_wb      ),
    .wb_waddr_i     ( rf_waddr_wb   ),
    .wb_wdata_i     ( rf_wdata_wb   ),
    .rf_rdata_a_i   ( rf_rdata_a    ),
    .rf_rdata_b_i   ( rf_rdata_b    ),
    .rf_raddr_a_o   ( rf_raddr_a    ),
    .rf_raddr_b_o   ( rf_raddr_b    ),
    .id_ex_o        ( id_ex_pipe    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute and writeback
  ////////////////////////////////////////////////////////////////////////////

  ex_stage ex_stage_i
  (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .id_ex_i        ( id_ex_pipe    ),
    .ex_wb_o        ( ex_wb_pipe    ),
    .ex_fwd_we_o    ( ex_fwd_we     ),
    .ex_fwd_rd_o    ( ex_fwd_rd     ),
    .ex_fwd_data_o  ( ex_fwd_data   )
  );

  wb_stage wb_stage_i
  (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .ex_wb_i        ( ex_wb_pipe     ),
    .rf_we_o        ( rf_we_wb       ),
    .rf_waddr_o     ( rf_waddr_wb    ),
    .rf_wdata_o     ( rf_wdata_wb    ),
    .wb_valid_o     ( wb_valid_o     ),
    .wb_rd_o        ( wb_rd_o        ),
    .wb_data_o      ( wb_data_o      ),
    .wb_pc_o        ( wb_pc_o        ),
    .illegal_o      ( illegal_o      ),
    .retire_count_o ( retire_count_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  register_file register_file_i
  (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .raddr_a_i      ( rf_raddr_a    ),
    .raddr_b_i      ( rf_raddr_b    ),
    .we_i           ( rf_we_wb      ),
    .waddr_i        ( rf_waddr_wb   ),
    .wdata_i        ( rf_wdata_wb   ),
    .rdata_a_o      ( rf_rdata_a    ),
    .rdata_b_o      ( rf_rdata_b    )
  );

endmodule

//--- design/wb_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module wb_stage import core_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ex_wb_pipe_t              ex_wb_i,

  // Register file write and WB forward
  output logic                     rf_we_o,
  output logic [`REG_ADDR_W-1:0]   rf_waddr_o,
  output logic [`XLEN-1:0]         rf_wdata_o,

  // Retirement view
  output logic                     wb_valid_o,
  output logic [`REG_ADDR_W-1:0]   wb_rd_o,
  output logic [`XLEN-1:0]         wb_data_o,
  output logic [`XLEN-1:0]         wb_pc_o,
  output logic                     illegal_o,
  output logic [`RETIRE_CNT_W-1:0] retire_count_o
);

  ex_wb_pipe_t              ex_wb_q;
  logic [`RETIRE_CNT_W-1:0] retire_cnt_q;

  // EX/WB register
  always_ff @(posedge clk_i) begin
    ex_wb_q <= ex_wb_i;
    if (!rst_n_i) begin
      ex_wb_q.valid <= 1'b0;
    end
  end

  // Counts with the load, so the count already includes the shown instruction
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      retire_cnt_q <= '0;
    end else if (ex_wb_i.valid && !ex_wb_i.illegal) begin
      retire_cnt_q <= retire_cnt_q + 1'b1;
    end
  end

  assign wb_valid_o = ex_wb_q.valid && !ex_wb_q.illegal;
  assign illegal_o  = ex_wb_q.valid && ex_wb_q.illegal;

  // x0 stays zero
  assign rf_we_o    = wb_valid_o && ex_wb_q.rd_we && (ex_wb_q.rd != '0);
  assign rf_waddr_o = ex_wb_q.rd;
  assign rf_wdata_o = ex_wb_q.result;

  assign wb_rd_o        = ex_wb_q.rd;
  assign wb_data_o      = ex_wb_q.result;
  assign wb_pc_o        = ex_wb_q.pc;
  assign retire_count_o = retire_cnt_q;

  a_wb_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_valid_o && illegal_o))
    else $error("wb_valid_o and illegal_o both high");

endmodule

//--- design/ex_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module ex_stage import core_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  id_ex_pipe_t            id_ex_i,
  output ex_wb_pipe_t            ex_wb_o,

  // Combinational forward into decode
  output logic                   ex_fwd_we_o,
  output logic [`REG_ADDR_W-1:0] ex_fwd_rd_o,
  output logic [`XLEN-1:0]       ex_fwd_data_o
);

  id_ex_pipe_t      id_ex_q;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             lt_signed;
  logic             lt_unsigned;
  logic [`XLEN-1:0] result;

  // ID/EX register
  always_ff @(posedge clk_i) begin
    id_ex_q <= id_ex_i;
    if (!rst_n_i) begin
      id_ex_q.valid <= 1'b0;
    end
  end

  assign op_a  = id_ex_q.operand_a;
  assign op_b  = id_ex_q.operand_b;
  // Shift amount, low five bits only
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_q.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $signed(op_a) >>> shamt;
      ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      default:  result = op_b;
    endcase
  end

  // Forward only a live writer
  assign ex_fwd_we_o   = id_ex_q.valid && id_ex_q.rd_we;
  assign ex_fwd_rd_o   = id_ex_q.rd;
  assign ex_fwd_data_o = result;

  always_comb begin
    ex_wb_o.valid   = id_ex_q.valid;
    ex_wb_o.illegal = id_ex_q.illegal;
    ex_wb_o.rd      = id_ex_q.rd;
    ex_wb_o.rd_we   = id_ex_q.rd_we;
    ex_wb_o.result  = result;
    ex_wb_o.pc      = id_ex_q.pc;
  end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module decode_stage import core_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  if_id_pipe_t            if_id_i,

  // Forward from EX, youngest value
  input  logic                   ex_fwd_we_i,
  input  logic [`REG_ADDR_W-1:0] ex_fwd_rd_i,
  input  logic [`XLEN-1:0]       ex_fwd_data_i,

  // Forward from WB, written at the next edge
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [`XLEN-1:0]       wb_wdata_i,

  // Register file read ports
  input  logic [`XLEN-1:0]       rf_rdata_a_i,
  input  logic [`XLEN-1:0]       rf_rdata_b_i,
  output logic [`REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [`REG_ADDR_W-1:0] rf_raddr_b_o,

  output id_ex_pipe_t            id_ex_o
);

  if_id_pipe_t            if_id_q;

  // Instruction fields
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  logic                   f7_zero;
  logic                   f7_alt;

  // Immediates and operands
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_u;
  logic [`XLEN-1:0]       rs1_val;
  logic [`XLEN-1:0]       rs2_val;
  logic [`XLEN-1:0]       operand_a;
  logic [`XLEN-1:0]       operand_b;
  alu_op_e                alu_op;
  logic                   illegal;

  // IF/ID register, payload loads every cycle
  always_ff @(posedge clk_i) begin
    if_id_q <= if_id_i;
    if (!rst_n_i) begin
      if_id_q.valid <= 1'b0;
    end
  end

  assign opcode  = if_id_q.instr[6:0];
  assign rd      = if_id_q.instr[11:7];
  assign funct3  = if_id_q.instr[14:12];
  assign rs1     = if_id_q.instr[19:15];
  assign rs2     = if_id_q.instr[24:20];
  assign funct7  = if_id_q.instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // Sign-extended I-type, upper U-type
  assign imm_i = {{(`XLEN-12){if_id_q.instr[31]}}, if_id_q.instr[31:20]};
  assign imm_u = {if_id_q.instr[31:12], 12'b0};

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // Shared funct3 map of OP and OP-IMM
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // EX first, then WB, then the array
  // x0 never matches a forward
  function automatic logic [`XLEN-1:0] fwd_operand(
    input logic [`REG_ADDR_W-1:0] rs,
    input logic [`XLEN-1:0]       rf_val
  );
    logic [`XLEN-1:0] val;
    if (ex_fwd_we_i && (ex_fwd_rd_i != '0) && (ex_fwd_rd_i == rs)) begin
      val = ex_fwd_data_i;
    end else if (wb_we_i && (wb_waddr_i != '0) && (wb_waddr_i == rs)) begin
      val = wb_wdata_i;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = fwd_operand(rs1, rf_rdata_a_i);
    rs2_val = fwd_operand(rs2, rf_rdata_b_i);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    illegal   = 1'b0;
    operand_a = rs1_val;
    operand_b = rs2_val;
    case (opcode)
      OPCODE_OP: begin
        alu_op  = alu_from_funct3(funct3, f7_alt);
        // Alternate funct7 only on SUB and SRA
        illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OPCODE_OP_IMM: begin
        alu_op    = alu_from_funct3(funct3, f7_alt && (funct3 == 3'b101));
        operand_b = imm_i;
        // Shift immediates carry funct7 in the upper bits
        if (funct3 == 3'b001) begin
          illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          illegal = !(f7_zero || f7_alt);
        end
      end
      OPCODE_LUI: begin
        alu_op    = ALU_PASS_B;
        operand_a = '0;
        operand_b = imm_u;
      end
      OPCODE_AUIPC: begin
        operand_a = if_id_q.pc;
        operand_b = imm_u;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // ID/EX payload, illegal words never write
  always_comb begin
    id_ex_o.valid     = if_id_q.valid;
    id_ex_o.illegal   = illegal;
    id_ex_o.alu_op    = alu_op;
    id_ex_o.operand_a = operand_a;
    id_ex_o.operand_b = operand_b;
    id_ex_o.rd        = rd;
    id_ex_o.rd_we     = !illegal;
    id_ex_o.pc        = if_id_q.pc;
  end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module fetch_stage import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic             instr_valid_i,
  input  logic [`XLEN-1:0] instr_i,
  output if_id_pipe_t      if_id_o
);

  // One 32-bit word per instruction
  localparam logic [`XLEN-1:0] PC_STEP = `XLEN'd4;

  // Address of the next accepted word
  logic [`XLEN-1:0] pc_q;

  // Legal or not, every strobed word takes a slot
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= boot_addr_i;
    end else if (instr_valid_i) begin
      pc_q <= pc_q + PC_STEP;
    end
  end

  // Payload for the IF/ID register in decode
  always_comb begin
    if_id_o.valid = instr_valid_i;
    if_id_o.instr = instr_i;
    if_id_o.pc    = pc_q;
  end

  // Boot address must be word aligned, the step keeps it so
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pc_q[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pc_q);

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module register_file
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Combinational read ports
  input  logic [`REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`REG_ADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]       rdata_a_o,
  output logic [`XLEN-1:0]       rdata_b_o,

  // Single write port
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i
);

  // x1 to x31, x0 has no storage
  logic [`XLEN-1:0] regs_q [1:`NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // No write-through, decode forwards WB
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  // WB filters x0 before the write port
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> (waddr_i != '0))
    else $error("register file write to x0");

endmodule

//--- design/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

  // Major opcodes the decoder accepts
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'b0110011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B    // LUI, operand b straight through
  } alu_op_e;

  // Fetch to decode
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
  } if_id_pipe_t;

  // Decode to execute
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;
    logic [`XLEN-1:0]       pc;
  } id_ex_pipe_t;

  // Execute to writeback
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;
    logic [`XLEN-1:0]       result;
    logic [`XLEN-1:0]       pc;
  } ex_wb_pipe_t;

endpackage

//--- design/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and address width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Architectural registers, x0 included
`define NUM_REGS 32

// Retired instruction counter, wraps
`define RETIRE_CNT_W 16

`endif
